// File: design/sdCmdPkg.sv
package sdCmdPkg;

    // ============================================================
    // frame geometry
    // ============================================================
    // command and short response are both 48 bits on the line
    localparam int frameBits = 48;
    localparam int crcBits   = 7;

    // ============================================================
    // request side
    // ============================================================
    // what the host expects back from the card
    typedef enum logic [1:0] {
        respNone  = 2'd0,
        // R1-like, crc checked
        respShort = 2'd1,
        // R3-like, crc field is all ones
        respOcr   = 2'd2
    } respKindT;

    // one host request
    typedef struct packed {
        logic [5:0]  index;
        logic [31:0] arg;
        respKindT    kind;
    } cmdReqT;

    // ============================================================
    // response side
    // ============================================================
    // 38 payload bits between transmission bit and crc
    // same bits read two ways, kind picks the view
    typedef union packed {
        struct packed {
            logic [5:0]  index;
            logic [31:0] cardStatus;
        } status;
        struct packed {
            // all ones from the card
            logic [5:0]  reserved;
            logic [31:0] ocr;
        } ocr;
    } respBodyT;

    // transaction result flags
    typedef struct packed {
        logic ok;
        logic crcError;
        logic frameError;
        logic noResponse;
    } respStatusT;

endpackage

// File: design/crc7Gen.sv
`timescale 1ns/10ps

module crc7Gen (
    input  logic                          int_clk,
    input  logic                          en,
    input  logic                          clear,
    input  logic                          bitEn,
    input  logic                          din,
    output logic [sdCmdPkg::crcBits-1:0] crc
);

    // x^7 + x^3 + 1, feedback lands on bits 0 and 3
    logic fb;
    assign fb = din ^ crc[6];

    always_ff @(posedge int_clk or negedge en) begin
        if (!en) begin
            crc <= '0;
        end else if (clear) begin
            crc <= '0;
        end else if (bitEn) begin
            crc <= {crc[5:3], crc[2] ^ fb, crc[1:0], fb};
        end
    end

endmodule

// File: design/sdClkGen.sv
`timescale 1ns/10ps

module sdClkGen #(
    parameter int clkDivHalf = 4
) (
    input  logic int_clk,
    input  logic en,
    output logic sdClk,
    output logic riseStb,
    output logic fallStb
);

    // counter width, at least one bit
    localparam int cntW = (clkDivHalf > 1) ? $clog2(clkDivHalf) : 1;

    logic [cntW-1:0] divCnt;
    logic            halfDone;

    // last int_clk cycle of a half period
    assign halfDone = (divCnt == cntW'(clkDivHalf - 1));

    // strobes line up with the cycle where sdClk has just changed
    always_ff @(posedge int_clk or negedge en) begin
        if (!en) begin
            divCnt  <= '0;
            sdClk   <= 1'b0;
            riseStb <= 1'b0;
            fallStb <= 1'b0;
        end else begin
            riseStb <= 1'b0;
            fallStb <= 1'b0;
            if (halfDone) begin
                divCnt  <= '0;
                sdClk   <= ~sdClk;
                // low now means going high
                riseStb <= ~sdClk;
                fallStb <= sdClk;
            end else begin
                divCnt <= divCnt + 1'b1;
            end
        end
    end

endmodule

// File: design/cmdTransmitter.sv
`timescale 1ns/10ps

module cmdTransmitter (
    input  logic             int_clk,
    input  logic             en,
    input  logic             fallStb,
    input  logic             txStart,
    input  sdCmdPkg::cmdReqT cmdReq,
    output logic             cmdOut,
    output logic             cmdOe,
    output logic             txDone
);

    // ============================================================
    // frame shifter
    // ============================================================
    logic [sdCmdPkg::frameBits-1:0] shiftReg;
    // bits still to send, 48 down to 0
    logic [5:0]                     bitCnt;
    logic                           active;
    logic [sdCmdPkg::crcBits-1:0]   crc;
    logic [2:0]                     crcIdx;
    logic                           crcPhase;
    logic                           hdrBit;
    logic                           txBit;

    // remaining 8..2 are the crc slots, msb first
    assign crcPhase = (bitCnt <= 6'(sdCmdPkg::crcBits + 1)) && (bitCnt > 6'd1);
    // header bits are the first 40 sent
    assign hdrBit   = active && (bitCnt > 6'(sdCmdPkg::crcBits + 1));
    // 8 wraps to 6, 2 maps to 0
    assign crcIdx   = bitCnt[2:0] - 3'd2;
    assign txBit    = crcPhase ? crc[crcIdx] : shiftReg[sdCmdPkg::frameBits-1];

    // running crc over header bits only
    crc7Gen crcTx (
        .int_clk(int_clk),
        .en     (en),
        .clear  (txStart),
        .bitEn  (fallStb && hdrBit),
        .din    (shiftReg[sdCmdPkg::frameBits-1]),
        .crc    (crc)
    );

    // crc field left zero, filled in on the fly
    always_ff @(posedge int_clk) begin
        if (txStart) begin
            shiftReg <= {2'b01, cmdReq.index, cmdReq.arg,
                         {sdCmdPkg::crcBits{1'b0}}, 1'b1};
        end else if (fallStb && active) begin
            shiftReg <= shiftReg << 1;
        end
    end

    // ============================================================
    // line control
    // ============================================================
    always_ff @(posedge int_clk or negedge en) begin
        if (!en) begin
            bitCnt <= '0;
            active <= 1'b0;
            cmdOut <= 1'b1;
            cmdOe  <= 1'b0;
            txDone <= 1'b0;
        end else begin
            txDone <= 1'b0;
            if (txStart) begin
                bitCnt <= 6'(sdCmdPkg::frameBits);
                active <= 1'b1;
            end else if (fallStb && active) begin
                if (bitCnt != 6'd0) begin
                    cmdOut <= txBit;
                    cmdOe  <= 1'b1;
                    bitCnt <= bitCnt - 1'b1;
                end else begin
                    // stop bit held a full period, release line
                    cmdOut <= 1'b1;
                    cmdOe  <= 1'b0;
                    active <= 1'b0;
                    txDone <= 1'b1;
                end
            end
        end
    end

endmodule

// File: design/respReceiver.sv
`timescale 1ns/10ps

module respReceiver #(
    parameter int respWaitLimit = 64
) (
    input  logic                 int_clk,
    input  logic                 en,
    input  logic                 riseStb,
    input  logic                 rxStart,
    input  sdCmdPkg::respKindT   kind,
    input  logic                 cmdIn,
    output logic                 rxDone,
    output sdCmdPkg::respStatusT rxFlags,
    output sdCmdPkg::respBodyT   respBody
);

    localparam int waitW = $clog2(respWaitLimit + 1);

    localparam logic [1:0] stIdle  = 2'd0;
    localparam logic [1:0] stWait  = 2'd1;
    localparam logic [1:0] stShift = 2'd2;
    localparam logic [1:0] stCheck = 2'd3;

    logic [1:0]                     state;
    logic [waitW-1:0]               waitCnt;
    logic [5:0]                     bitCnt;
    // frame bits 1..47, start bit not kept
    logic [sdCmdPkg::frameBits-2:0] shiftReg;
    sdCmdPkg::respKindT             kindReg;
    logic [sdCmdPkg::crcBits-1:0]   crc;
    logic                           startSeen;
    logic                           crcBitEn;

    assign startSeen = (state == stWait) && riseStb && !cmdIn;
    // start bit plus the next 39 go into the crc
    assign crcBitEn  = startSeen ||
                       ((state == stShift) && riseStb &&
                        (bitCnt > 6'(sdCmdPkg::crcBits + 1)));

    crc7Gen crcRx (
        .int_clk(int_clk),
        .en     (en),
        .clear  (rxStart),
        .bitEn  (crcBitEn),
        .din    (cmdIn),
        .crc    (crc)
    );

    // ============================================================
    // payload capture
    // ============================================================
    always_ff @(posedge int_clk) begin
        if (rxStart) begin
            kindReg <= kind;
        end
        if ((state == stShift) && riseStb) begin
            shiftReg <= {shiftReg[sdCmdPkg::frameBits-3:0], cmdIn};
        end
        // body only moves on a complete frame
        if (state == stCheck) begin
            respBody <= shiftReg[45:8];
        end
    end

    // ============================================================
    // receive FSM
    // ============================================================
    always_ff @(posedge int_clk or negedge en) begin
        if (!en) begin
            state   <= stIdle;
            waitCnt <= '0;
            bitCnt  <= '0;
            rxDone  <= 1'b0;
            rxFlags <= '0;
        end else begin
            rxDone <= 1'b0;
            case (state)
                stIdle: begin
                    if (rxStart) begin
                        waitCnt <= '0;
                        state   <= stWait;
                    end
                end
                stWait: begin
                    if (startSeen) begin
                        bitCnt <= 6'(sdCmdPkg::frameBits - 1);
                        state  <= stShift;
                    end else if (riseStb) begin
                        // card never answered
                        if (waitCnt == waitW'(respWaitLimit - 1)) begin
                            rxFlags <= '{ok: 1'b0, crcError: 1'b0,
                                         frameError: 1'b0, noResponse: 1'b1};
                            rxDone  <= 1'b1;
                            state   <= stIdle;
                        end else begin
                            waitCnt <= waitCnt + 1'b1;
                        end
                    end
                end
                stShift: begin
                    if (riseStb) begin
                        bitCnt <= bitCnt - 1'b1;
                        // stop bit just taken
                        if (bitCnt == 6'd1) begin
                            state <= stCheck;
                        end
                    end
                end
                default: begin
                    // transmission bit 0, stop bit 1
                    rxFlags.ok         <= 1'b0;
                    rxFlags.noResponse <= 1'b0;
                    rxFlags.frameError <= shiftReg[46] || !shiftReg[0];
                    // ocr replies carry no real crc
                    rxFlags.crcError   <= (kindReg == sdCmdPkg::respShort) &&
                                          (crc != shiftReg[sdCmdPkg::crcBits:1]);
                    rxDone <= 1'b1;
                    state  <= stIdle;
                end
            endcase
        end
    end

endmodule

// File: design/cmdSequencer.sv
`timescale 1ns/10ps

module cmdSequencer (
    input  logic                 int_clk,
    input  logic                 en,
    input  logic                 cmdStart,
    input  sdCmdPkg::cmdReqT     cmdReq,
    input  logic                 txDone,
    input  logic                 rxDone,
    input  sdCmdPkg::respStatusT rxFlags,
    output logic                 txStart,
    output sdCmdPkg::cmdReqT     heldReq,
    output logic                 rxStart,
    output logic                 busy,
    output logic                 done,
    output sdCmdPkg::respStatusT status
);

    localparam logic [1:0] stIdle = 2'd0;
    localparam logic [1:0] stTx   = 2'd1;
    localparam logic [1:0] stRx   = 2'd2;

    logic [1:0] state;
    logic       accept;

    // starts only count while idle
    assign accept = (state == stIdle) && cmdStart;

    // request held for the whole transaction
    always_ff @(posedge int_clk) begin
        if (accept) begin
            heldReq <= cmdReq;
        end
    end

    // ============================================================
    // transaction control
    // ============================================================
    always_ff @(posedge int_clk or negedge en) begin
        if (!en) begin
            state   <= stIdle;
            txStart <= 1'b0;
            rxStart <= 1'b0;
            busy    <= 1'b0;
            done    <= 1'b0;
            status  <= '0;
        end else begin
            txStart <= 1'b0;
            rxStart <= 1'b0;
            done    <= 1'b0;
            case (state)
                stIdle: begin
                    if (accept) begin
                        txStart <= 1'b1;
                        busy    <= 1'b1;
                        state   <= stTx;
                    end
                end
                stTx: begin
                    if (txDone) begin
                        if (heldReq.kind == sdCmdPkg::respNone) begin
                            // nothing to receive, finish now
                            status <= '{ok: 1'b1, crcError: 1'b0,
                                        frameError: 1'b0, noResponse: 1'b0};
                            done   <= 1'b1;
                            busy   <= 1'b0;
                            state  <= stIdle;
                        end else begin
                            rxStart <= 1'b1;
                            state   <= stRx;
                        end
                    end
                end
                default: begin
                    if (rxDone) begin
                        // ok only when no flag came back
                        status.ok         <= !(rxFlags.crcError || rxFlags.frameError ||
                                               rxFlags.noResponse);
                        status.crcError   <= rxFlags.crcError;
                        status.frameError <= rxFlags.frameError;
                        status.noResponse <= rxFlags.noResponse;
                        done  <= 1'b1;
                        busy  <= 1'b0;
                        state <= stIdle;
                    end
                end
            endcase
        end
    end

endmodule

// File: design/sdCmdCtrl.sv
`timescale 1ns/10ps

module sdCmdCtrl #(
    parameter int clkDivHalf    = 4,
    parameter int respWaitLimit = 64
) (
    input  logic                 int_clk,
    input  logic                 en,
    // host side
    input  logic                 cmdStart,
    input  sdCmdPkg::cmdReqT     cmdReq,
    output logic                 busy,
    output logic                 done,
    output sdCmdPkg::respStatusT status,
    output sdCmdPkg::respBodyT   respBody,
    // card side, pin split outside
    output logic                 sdClk,
    output logic                 cmdOut,
    output logic                 cmdOe,
    input  logic                 cmdIn
);

    logic                 riseStb;
    logic                 fallStb;
    logic                 txStart;
    logic                 txDone;
    logic                 rxStart;
    logic                 rxDone;
    sdCmdPkg::cmdReqT     heldReq;
    sdCmdPkg::respStatusT rxFlags;

    sdClkGen #(.clkDivHalf(clkDivHalf)) clkGen (
        .int_clk(int_clk), .en(en),
        .sdClk(sdClk), .riseStb(riseStb), .fallStb(fallStb)
    );

    cmdTransmitter tx (
        .int_clk(int_clk), .en(en), .fallStb(fallStb),
        .txStart(txStart), .cmdReq(heldReq),
        .cmdOut(cmdOut), .cmdOe(cmdOe), .txDone(txDone)
    );

    respReceiver #(.respWaitLimit(respWaitLimit)) rx (
        .int_clk(int_clk), .en(en), .riseStb(riseStb),
        .rxStart(rxStart), .kind(heldReq.kind), .cmdIn(cmdIn),
        .rxDone(rxDone), .rxFlags(rxFlags), .respBody(respBody)
    );

    cmdSequencer seq (
        .int_clk(int_clk), .en(en), .cmdStart(cmdStart), .cmdReq(cmdReq),
        .txDone(txDone), .rxDone(rxDone), .rxFlags(rxFlags),
        .txStart(txStart), .heldReq(heldReq), .rxStart(rxStart),
        .busy(busy), .done(done), .status(status)
    );

endmodule

// File: bench/sdCmdCtrl_assert.sv
`timescale 1ns/10ps

module sdCmdCtrl_assert (
    input logic int_clk,
    input logic en,
    input logic cmdStart,
    input logic busy,
    input logic done,
    input logic cmdOe
);

    // host only drives the line inside a transaction
    cmdOeInBusy: assert property (@(posedge int_clk) disable iff (!en)
        cmdOe |-> busy)
        else $error("cmdOe high while busy is low");

    // single-cycle end marker
    doneOneCycle: assert property (@(posedge int_clk) disable iff (!en)
        done |=> !done)
        else $error("done held for more than one cycle");

    doneNotBusy: assert property (@(posedge int_clk) disable iff (!en)
        done |-> !busy)
        else $error("busy still high in the done cycle");

    // accepted start shows up as busy one cycle later
    busyAfterStart: assert property (@(posedge int_clk) disable iff (!en)
        (cmdStart && !busy) |=> busy)
        else $error("busy did not rise after an accepted cmdStart");

endmodule

bind sdCmdCtrl sdCmdCtrl_assert chk (
    .int_clk(int_clk), .en(en), .cmdStart(cmdStart),
    .busy(busy), .done(done), .cmdOe(cmdOe)
);

// File: bench/sdCmdCtrlTb.sv
`timescale 1ns/10ps

module sdCmdCtrlTb;

    localparam int clkDivHalf    = 4;
    localparam int respWaitLimit = 64;
    // worst-case ns for one transaction in sdClk periods times period
    localparam longint lineBudgetNs = (2 * 48 + respWaitLimit + 8) * 2 * clkDivHalf * 8;

    // one transaction from the data file
    typedef struct packed {
        sdCmdPkg::cmdReqT     req;
        sdCmdPkg::respBodyT   payload;
        logic                 corruptCrc;
        logic                 badStop;
        logic                 silent;
        sdCmdPkg::respStatusT expStatus;
    } testVecT;

    logic                 int_clk = 1'b0;
    logic                 en;
    logic                 cmdStart;
    sdCmdPkg::cmdReqT     cmdReq;
    logic                 busy;
    logic                 done;
    sdCmdPkg::respStatusT status;
    sdCmdPkg::respBodyT   respBody;
    logic                 sdClk;
    logic                 cmdOut;
    logic                 cmdOe;
    logic                 cmdIn;

    testVecT vecs[$];
    int      vecCount = 0;
    integer  seed = 12002;

    // 8 ns period
    always #4 int_clk = ~int_clk;

    sdCmdCtrl #(.clkDivHalf(clkDivHalf), .respWaitLimit(respWaitLimit)) uut (
        .int_clk(int_clk), .en(en), .cmdStart(cmdStart), .cmdReq(cmdReq),
        .busy(busy), .done(done), .status(status), .respBody(respBody),
        .sdClk(sdClk), .cmdOut(cmdOut), .cmdOe(cmdOe), .cmdIn(cmdIn)
    );

    // ============================================================
    // reference model and checks
    // ============================================================
    // crc7 of x^7 + x^3 + 1 from zero with msb first
    function automatic logic [6:0] crc7Of(input logic [39:0] bits);
        logic [6:0] r;
        logic       fb;
        r = '0;
        for (int i = 39; i >= 0; i--) begin
            fb = bits[i] ^ r[6];
            r  = {r[5:0], 1'b0} ^ (fb ? 7'h09 : 7'h00);
        end
        return r;
    endfunction

    task automatic abortRun(input string why);
        $display("%s", why);
        $display("Some tests failed");
        $fatal(1, "run stopped");
    endtask

    // whole frame covers start, transmission, index, arg, crc and stop
    task automatic checkReq(input sdCmdPkg::cmdReqT exp, input logic [47:0] frame);
        logic [39:0] head;
        logic [47:0] want;
        head = {2'b01, exp.index, exp.arg};
        want = {head, crc7Of(head), 1'b1};
        if (frame !== want) begin
            abortRun($sformatf("CHECK FAILED at %0t: cmdOut frame expected %h got %h",
                               $time, want, frame));
        end
    endtask

    task automatic checkStatus(input sdCmdPkg::respStatusT exp,
                               input sdCmdPkg::respStatusT got);
        if (got !== exp) begin
            abortRun($sformatf("CHECK FAILED at %0t: status expected %b got %b",
                               $time, exp, got));
        end
    endtask

    task automatic checkBody(input sdCmdPkg::respBodyT exp, input sdCmdPkg::respBodyT got);
        if (got !== exp) begin
            abortRun($sformatf("CHECK FAILED at %0t: respBody expected %h got %h",
                               $time, exp, got));
        end
    endtask

    // ============================================================
    // host and card model
    // ============================================================
    task automatic issueStart(input sdCmdPkg::cmdReqT req);
        @(posedge int_clk);
        cmdStart <= 1'b1;
        cmdReq   <= req;
        @(posedge int_clk);
        cmdStart <= 1'b0;
    endtask

    // junk request mid-command that must be dropped
    task automatic startWhileBusy(input sdCmdPkg::cmdReqT req);
        sdCmdPkg::cmdReqT junk;
        junk       = req;
        junk.index = ~req.index;
        junk.arg   = ~req.arg;
        do begin
            @(posedge int_clk);
        end while (busy !== 1'b1);
        repeat (3) @(posedge int_clk);
        issueStart(junk);
    endtask

    // card samples on sdClk rise while the host drives
    task automatic captureCommand(output logic [47:0] frame);
        int n;
        n     = 0;
        frame = '0;
        while (n < 48) begin
            @(posedge sdClk);
            if (cmdOe) begin
                frame = {frame[46:0], cmdOut};
                n++;
            end
        end
    endtask

    // sdClk edges land on int_clk rising edges
    task automatic sendResponse(input testVecT v);
        logic [6:0]  crcField;
        logic [47:0] resp;
        // ocr replies carry all ones instead of a crc
        crcField = (v.req.kind == sdCmdPkg::respOcr) ? 7'h7f : crc7Of({2'b00, v.payload});
        if (v.corruptCrc) begin
            crcField = ~crcField;
        end
        resp = {2'b00, v.payload, crcField, !v.badStop};
        // two idle periods after the stop bit
        repeat (2) @(negedge sdClk);
        for (int i = 47; i >= 0; i--) begin
            @(negedge sdClk);
            cmdIn <= resp[i];
        end
        @(negedge sdClk);
        cmdIn <= 1'b1;
    endtask

    // returns on the edge that closes the done cycle
    task automatic waitDone();
        do begin
            @(posedge int_clk);
        end while (done !== 1'b1);
    endtask

    task automatic runTransaction(input testVecT v);
        logic [47:0] frame;
        int          gap;
        gap = $unsigned($random(seed)) % 16;
        repeat (gap) @(posedge int_clk);
        issueStart(v.req);
        fork
            captureCommand(frame);
            startWhileBusy(v.req);
        join
        checkReq(v.req, frame);
        fork
            begin
                if (!v.silent && v.req.kind != sdCmdPkg::respNone) begin
                    sendResponse(v);
                end
            end
            waitDone();
        join
        checkStatus(v.expStatus, status);
        if (!v.silent && v.req.kind != sdCmdPkg::respNone) begin
            checkBody(v.payload, respBody);
        end
    endtask

    // lines starting with # are column notes
    task automatic loadVectors();
        int          fd;
        int          got;
        string       line;
        logic [5:0]  idx;
        logic [31:0] arg;
        logic [1:0]  kind;
        logic [37:0] payload;
        logic        corrupt;
        logic        badStop;
        logic        silent;
        logic [3:0]  expStat;
        testVecT     v;
        fd = $fopen("bench/sdCmdTestdata.txt", "r");
        if (fd == 0) begin
            abortRun("could not open the data file bench/sdCmdTestdata.txt");
        end else begin
            while (!$feof(fd)) begin
                got = $fgets(line, fd);
                if (got > 0 && line[0] != "#") begin
                    got = $sscanf(line, "%h %h %h %h %h %h %h %h", idx, arg, kind,
                                  payload, corrupt, badStop, silent, expStat);
                    if (got == 8) begin
                        v.req.index  = idx;
                        v.req.arg    = arg;
                        v.req.kind   = sdCmdPkg::respKindT'(kind);
                        v.payload    = payload;
                        v.corruptCrc = corrupt;
                        v.badStop    = badStop;
                        v.silent     = silent;
                        v.expStatus  = expStat;
                        vecs.push_back(v);
                    end
                end
            end
            $fclose(fd);
            if (vecs.size() == 0) begin
                abortRun("the data file holds no transactions");
            end else begin
                vecCount = vecs.size();
            end
        end
    endtask

    // ============================================================
    // main sequence and watchdog
    // ============================================================
    initial begin
        en       = 1'b0;
        cmdStart = 1'b0;
        cmdReq   = '0;
        cmdIn    = 1'b1;
        loadVectors();
        repeat (8) @(posedge int_clk);
        en <= 1'b1;
        foreach (vecs[i]) begin
            runTransaction(vecs[i]);
        end
        $display("All tests passed");
        $finish;
    end

    initial begin
        wait (vecCount > 0);
        #(vecCount * lineBudgetNs);
        abortRun($sformatf("timeout, %0d transactions did not finish within %0d ns",
                           vecCount, vecCount * lineBudgetNs));
    end

endmodule

// File: bench/sdCmdTestdata.txt
# columns are index arg kind payload corruptCrc badStop silent expStatus in hex
# kind 0 none 1 short 2 ocr and expStatus is ok crcError frameError noResponse as 4 bits
00 00000000 0 0000000000 0 0 0 8
08 000001aa 1 08000001aa 0 0 0 8
37 00000000 1 3700000120 0 0 0 8
29 40300000 2 3f80ff8000 0 0 0 8
0f 00000000 0 0000000000 0 0 0 8
03 00000000 1 03aaaa0500 0 0 0 8
07 aaaa0000 1 0700000700 1 0 0 4
0d aaaa0000 1 0d00000900 0 1 0 2
11 00000200 1 1100000900 0 0 1 1
3a 00000000 2 3fc0ff8000 1 0 0 8
0f aaaa0000 0 0000000000 0 0 0 8
10 00000200 1 1000000900 0 0 0 8
18 deadbeef 1 1800000900 0 0 0 8
29 00ff8000 2 3f00ff8000 0 1 0 2
29 00ff8000 2 0000000000 0 0 1 1
19 12345678 1 19c0ffee00 1 1 0 6
0d aaaa0000 1 0d00000900 0 0 0 8

// File: list.f
design/sdCmdPkg.sv
design/crc7Gen.sv
design/sdClkGen.sv
design/cmdTransmitter.sv
design/respReceiver.sv
design/cmdSequencer.sv
design/sdCmdCtrl.sv
bench/sdCmdCtrl_assert.sv
bench/sdCmdCtrlTb.sv

// File: run.sh
#!/usr/bin/env bash
# builds and runs the sdCmdCtrl testbench with Verilator
# all paths are relative to the project root

cd "$(dirname "$0")" || exit 1

buildLog=build.log
simLog=sim.log

verilator --binary --timing --assert --timescale 1ns/10ps -Wno-fatal \
    --top-module sdCmdCtrlTb -Mdir obj_dir -o simv -f list.f > "$buildLog" 2>&1
if [ $? -ne 0 ]; then
    echo "build failed, see $buildLog"
    exit 1
fi

./obj_dir/simv > "$simLog" 2>&1
simStatus=$?
cat "$simLog"
if [ $simStatus -ne 0 ]; then
    echo "simulator exited with status $simStatus"
    exit 1
fi

if grep -qx "All tests passed" "$simLog"; then
    echo "RESULT: PASS"
    exit 0
else
    echo "RESULT: FAIL"
    exit 1
fi
